// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module alu
    import rvPkg::*;
(
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  aluOpT               aluOp,
    input  brTypeT              brType,
    output logic [`RV_XLEN-1:0] result,
    output logic                taken
);

    logic [4:0] shamt;
    logic       ltS;  // Signed less-than
    logic       ltU;  // Unsigned less-than
    logic       eq;

    assign shamt = b[4:0];  // Shift amount, upper bits ignored
    assign ltS   = $signed(a) < $signed(b);
    assign ltU   = a < b;
    assign eq    = (a == b);

    always_comb begin
        case (aluOp)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluSll:   result = a << shamt;
            aluSlt:   result = {{(`RV_XLEN-1){1'b0}}, ltS};
            aluSltu:  result = {{(`RV_XLEN-1){1'b0}}, ltU};
            aluXor:   result = a ^ b;
            aluSrl:   result = a >> shamt;
            aluSra:   result = $signed(a) >>> shamt;  // Arithmetic, sign fill
            aluOr:    result = a | b;
            aluAnd:   result = a & b;
            aluPassB: result = b;
            default:  result = '0;
        endcase
    end

    // Branch decision, b holds rs2 for branches
    always_comb begin
        case (brType)
            brEq:    taken = eq;
            brNe:    taken = !eq;
            brLt:    taken = ltS;
            brGe:    taken = !ltS;
            brLtu:   taken = ltU;
            brGeu:   taken = !ltU;
            default: taken = 1'b0;  // Not a branch
        endcase
    end

endmodule

// ==== hdl/controller.sv ====
`timescale 1ns/1ps

module controller
    import rvPkg::*;
(
    input  logic [31:0] instr,
    output ctrlT        ctrl
);

    // First level of the ALU decode
    typedef enum logic [2:0] {clsAdd, clsSub, clsImm, clsReg, clsPass} aluClsT;

    opcodeT     opcode;
    logic [2:0] func3;
    logic       func7b5;   // Only bit 5 of func7 matters here
    aluClsT     aluCls;
    aluOpT      aluOp;
    brTypeT     brType;
    wbSelT      wbSel;
    jmpT        jmp;
    logic       aluSrcImm;
    logic       regWrite;
    logic       memWrite;
    accSizeT    accSize;

    assign opcode  = opcodeT'(instr[6:0]);
    assign func3   = instr[14:12];
    assign func7b5 = instr[30];

    // Write-back source
    muxKeyWithDefault #(.NumKeys(4), .KeyLen(7), .payloadT(wbSelT)) muxWbSel (
        .key(opcode),
        .lut({opLoad,  wbLoad,    // Memory data
              opJalr,  wbPc4,     // Link
              opJal,   wbPc4,
              opAuipc, wbPcImm}),
        .defaultOut(wbAlu),
        .out(wbSel)
    );

    muxKeyWithDefault #(.NumKeys(1), .KeyLen(7), .payloadT(logic)) muxMemWrite (
        .key(opcode),
        .lut({opStore, 1'b1}),
        .defaultOut(1'b0),
        .out(memWrite)
    );

    // Branch kind from opcode plus func3
    muxKeyWithDefault #(.NumKeys(6), .KeyLen(10), .payloadT(brTypeT)) muxBrType (
        .key({opcode, func3}),
        .lut({opBranch, 3'b000, brEq,
              opBranch, 3'b001, brNe,
              opBranch, 3'b100, brLt,
              opBranch, 3'b101, brGe,
              opBranch, 3'b110, brLtu,
              opBranch, 3'b111, brGeu}),
        .defaultOut(brNone),
        .out(brType)
    );

    muxKeyWithDefault #(.NumKeys(2), .KeyLen(7), .payloadT(jmpT)) muxJmp (
        .key(opcode),
        .lut({opJal,  jmpJal,
              opJalr, jmpJalr}),
        .defaultOut(jmpNone),
        .out(jmp)
    );

    // Imm feeds ALU b for addresses, I type ops, jalr and lui
    muxKeyWithDefault #(.NumKeys(5), .KeyLen(7), .payloadT(logic)) muxAluSrc (
        .key(opcode),
        .lut({opLoad,  1'b1,
              opStore, 1'b1,
              opImm,   1'b1,
              opJalr,  1'b1,
              opLui,   1'b1}),
        .defaultOut(1'b0),
        .out(aluSrcImm)
    );

    // Unknown opcodes never write
    muxKeyWithDefault #(.NumKeys(7), .KeyLen(7), .payloadT(logic)) muxRegWrite (
        .key(opcode),
        .lut({opReg,   1'b1,
              opLoad,  1'b1,
              opImm,   1'b1,
              opJalr,  1'b1,
              opLui,   1'b1,
              opAuipc, 1'b1,
              opJal,   1'b1}),
        .defaultOut(1'b0),
        .out(regWrite)
    );

    muxKeyWithDefault #(.NumKeys(4), .KeyLen(7), .payloadT(aluClsT)) muxAluCls (
        .key(opcode),
        .lut({opBranch, clsSub,
              opImm,    clsImm,
              opReg,    clsReg,
              opLui,    clsPass}),
        .defaultOut(clsAdd),   // Address and link arithmetic
        .out(aluCls)
    );

    // Second level refines the class by func3 and func7
    always_comb begin
        aluOp = aluAdd;
        case (aluCls)
            clsSub:  aluOp = aluSub;
            clsPass: aluOp = aluPassB;
            clsImm: begin
                case (func3)
                    3'b010:  aluOp = aluSlt;
                    3'b011:  aluOp = aluSltu;
                    3'b100:  aluOp = aluXor;
                    3'b110:  aluOp = aluOr;
                    3'b111:  aluOp = aluAnd;
                    default: aluOp = aluAdd;  // addi
                endcase
            end
            clsReg: begin
                case ({func7b5, func3})
                    4'b1000: aluOp = aluSub;
                    4'b0001: aluOp = aluSll;
                    4'b0010: aluOp = aluSlt;
                    4'b0011: aluOp = aluSltu;
                    4'b0100: aluOp = aluXor;
                    4'b0101: aluOp = aluSrl;
                    4'b1101: aluOp = aluSra;
                    4'b0110: aluOp = aluOr;
                    4'b0111: aluOp = aluAnd;
                    default: aluOp = aluAdd;
                endcase
            end
            default: aluOp = aluAdd;
        endcase
    end

    // Access width from func3[1:0]
    always_comb begin
        case (func3[1:0])
            2'b00:   accSize = accByte;
            2'b01:   accSize = accHalf;
            default: accSize = accWord;
        endcase
    end

    always_comb begin
        ctrl.aluOp      = aluOp;
        ctrl.brType     = brType;
        ctrl.wbSel      = wbSel;
        ctrl.jmp        = jmp;
        ctrl.aluSrcImm  = aluSrcImm;
        ctrl.regWrite   = regWrite;
        ctrl.memWrite   = memWrite;
        ctrl.accSize    = accSize;
        ctrl.loadSigned = (opcode == opLoad) && !func3[2];  // Set for lb and lh
    end

endmodule

// ==== hdl/immGen.sv ====
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module immGen
    import rvPkg::*;
(
    input  logic [31:0]         instr,
    output logic [`RV_XLEN-1:0] imm
);

    opcodeT opcode;
    logic   sign;  // Every format takes its sign from bit 31

    assign opcode = opcodeT'(instr[6:0]);
    assign sign   = instr[31];

    always_comb begin
        case (opcode)
            // I type
            opLoad, opImm, opJalr:
                imm = {{(`RV_XLEN-12){sign}}, instr[31:20]};
            // S type, split field
            opStore:
                imm = {{(`RV_XLEN-12){sign}}, instr[31:25], instr[11:7]};
            // B type, bit 0 implied zero
            opBranch:
                imm = {{(`RV_XLEN-13){sign}}, sign, instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            // U type
            opLui, opAuipc:
                imm = {instr[31:12], 12'b0};  // Low bits zero filled
            // J type
            opJal:
                imm = {{(`RV_XLEN-21){sign}}, sign, instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

// ==== hdl/lsuAlign.sv ====
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module lsuAlign
    import rvPkg::*;
(
    input  logic [`RV_XLEN-1:0] addr,
    input  logic [`RV_XLEN-1:0] storeData,
    input  logic [`RV_XLEN-1:0] rdata,
    input  ctrlT                ctrl,
    output dataReqT             dataReq,
    output logic [`RV_XLEN-1:0] loadData
);

    logic [1:0]  offs;       // Byte offset inside the word
    logic [7:0]  byteLane;
    logic [15:0] halfLane;
    logic [3:0]  strb;

    assign offs = addr[1:0];

    // Store side
    always_comb begin
        case (ctrl.accSize)
            accByte: begin
                dataReq.wdata = {4{storeData[7:0]}};  // Byte in every lane
                strb          = 4'b0001 << offs;
            end
            accHalf: begin
                dataReq.wdata = {2{storeData[15:0]}};
                strb          = offs[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                dataReq.wdata = storeData;
                strb          = 4'b1111;
            end
        endcase
        dataReq.addr  = {addr[`RV_XLEN-1:2], 2'b00};
        dataReq.wstrb = ctrl.memWrite ? strb : 4'b0000;  // Only stores write
    end

    // Load side, pick the lane then extend
    assign byteLane = rdata[{offs, 3'b000} +: 8];
    assign halfLane = offs[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (ctrl.accSize)
            accByte:
                loadData = {{(`RV_XLEN-8){ctrl.loadSigned & byteLane[7]}}, byteLane};
            accHalf:
                loadData = {{(`RV_XLEN-16){ctrl.loadSigned & halfLane[15]}}, halfLane};
            default:
                loadData = rdata;  // lw
        endcase
    end

endmodule

// ==== hdl/muxKeyWithDefault.sv ====
`timescale 1ns/1ps

// Generic key -> payload lookup, first table entry sits at the MSB end
module muxKeyWithDefault #(
    parameter int NumKeys = 2,
    parameter int KeyLen = 7,
    parameter type payloadT = logic
) (
    input  logic [KeyLen-1:0]                                key,
    input  logic [NumKeys-1:0][KeyLen+$bits(payloadT)-1:0]  lut,
    input  payloadT                                          defaultOut,
    output payloadT                                          out
);

    localparam int PayloadLen = $bits(payloadT);
    localparam int PairLen = KeyLen + PayloadLen;

    logic [PayloadLen-1:0] hitPayload; // Raw bits of the matching entry
    logic                  hit;

    // Linear scan, keys assumed unique
    always_comb begin
        hit = 1'b0;
        hitPayload = '0;
        for (int i = 0; i < NumKeys; i++) begin
            if (lut[i][PairLen-1 -: KeyLen] == key) begin
                hit = 1'b1;
                hitPayload = lut[i][PayloadLen-1:0];
            end
        end
    end

    assign out = hit ? payloadT'(hitPayload) : defaultOut; // Fall back on miss

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module regFile (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic [$clog2(`RV_NREGS)-1:0] rs1,
    input  logic [$clog2(`RV_NREGS)-1:0] rs2,
    input  logic [$clog2(`RV_NREGS)-1:0] rd,
    input  logic                        wen,
    input  logic [`RV_XLEN-1:0]         wdata,
    output logic [`RV_XLEN-1:0]         rs1Data,
    output logic [`RV_XLEN-1:0]         rs2Data
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    // x0 relies on the clear and a gated wen upstream
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[rd] <= wdata;
        end
    end

    // Combinational reads, no bypass
    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

endmodule

// ==== hdl/rvCore.sv ====
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module rvCore
    import rvPkg::*;
(
    input  logic                clk,
    input  logic                arstN,
    output logic [`RV_XLEN-1:0] pc,
    input  logic [31:0]         instr,
    output dataReqT             dataReq,
    input  logic [`RV_XLEN-1:0] rdata,
    output commitT              commit
);

    localparam int RegAw = $clog2(`RV_NREGS);

    ctrlT                ctrl;
    dataReqT             lsuReq;   // Ungated request from the LSU
    logic [RegAw-1:0]    rs1;
    logic [RegAw-1:0]    rs2;
    logic [RegAw-1:0]    rd;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rs1Data;
    logic [`RV_XLEN-1:0] rs2Data;
    logic [`RV_XLEN-1:0] aluB;
    logic [`RV_XLEN-1:0] result;
    logic                taken;
    logic [`RV_XLEN-1:0] loadData;
    logic [`RV_XLEN-1:0] pcPlus4;
    logic [`RV_XLEN-1:0] pcPlusImm;
    logic [`RV_XLEN-1:0] nextPc;
    logic [`RV_XLEN-1:0] wbData;
    logic                wen;

    assign rd  = instr[11:7];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    controller uCtrl (.instr(instr), .ctrl(ctrl));

    immGen uImm (.instr(instr), .imm(imm));

    regFile uRegs (
        .clk(clk), .arstN(arstN),
        .rs1(rs1), .rs2(rs2), .rd(rd),
        .wen(wen), .wdata(wbData),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    assign aluB = ctrl.aluSrcImm ? imm : rs2Data;

    alu uAlu (
        .a(rs1Data), .b(aluB),
        .aluOp(ctrl.aluOp), .brType(ctrl.brType),
        .result(result), .taken(taken)
    );

    lsuAlign uLsu (
        .addr(result), .storeData(rs2Data), .rdata(rdata),
        .ctrl(ctrl), .dataReq(lsuReq), .loadData(loadData)
    );

    assign pcPlus4   = pc + `RV_XLEN'd4;
    assign pcPlusImm = pc + imm;

    // Next PC, jalr target has bit 0 cleared
    always_comb begin
        if (ctrl.jmp == jmpJalr)
            nextPc = {result[`RV_XLEN-1:1], 1'b0};
        else if (ctrl.jmp == jmpJal || taken)
            nextPc = pcPlusImm;
        else
            nextPc = pcPlus4;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            pc <= `RV_RESET_PC;
        else
            pc <= nextPc;  // One instruction per cycle
    end

    // Write-back source
    always_comb begin
        case (ctrl.wbSel)
            wbLoad:  wbData = loadData;
            wbPc4:   wbData = pcPlus4;    // Link address
            wbPcImm: wbData = pcPlusImm;  // auipc
            default: wbData = result;
        endcase
    end

    assign wen = ctrl.regWrite && (rd != '0);  // x0 never written

    // No store leaves the core while in reset
    always_comb begin
        dataReq       = lsuReq;
        dataReq.wstrb = arstN ? lsuReq.wstrb : '0;
    end

    // Retirement record for the current instruction
    always_comb begin
        commit.valid = wen && arstN;
        commit.rd    = rd;
        commit.data  = wbData;
        commit.pc    = pc;
    end

endmodule

// ==== hdl/rvCore_defines.svh ====
`ifndef RVCORE_DEFINES_SVH
`define RVCORE_DEFINES_SVH

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Datapath width
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_NREGS 32

`endif

// ==== hdl/rvPkg.sv ====
`include "rvCore_defines.svh"

package rvPkg;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011, // lb lh lw lbu lhu
        opStore  = 7'b0100011, // sb sh sw
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opImm    = 7'b0010011, // addi and friends
        opReg    = 7'b0110011, // R type
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB  // lui, imm straight through
    } aluOpT;

    // Unsigned compares keep their own codes
    typedef enum logic [2:0] {brNone, brEq, brNe, brLt, brGe, brLtu, brGeu} brTypeT;

    // Write-back source
    typedef enum logic [1:0] {wbAlu, wbLoad, wbPc4, wbPcImm} wbSelT;

    typedef enum logic [1:0] {jmpNone, jmpJal, jmpJalr} jmpT;

    typedef enum logic [1:0] {accByte, accHalf, accWord} accSizeT;

    // Decoded control, 17 bits
    typedef struct packed {
        aluOpT   aluOp;
        brTypeT  brType;
        wbSelT   wbSel;
        jmpT     jmp;
        logic    aluSrcImm;  // 1 selects imm as ALU b
        logic    regWrite;
        logic    memWrite;
        accSizeT accSize;
        logic    loadSigned;
    } ctrlT;

    // Data port request
    typedef struct packed {
        logic [`RV_XLEN-1:0]   addr;   // Word aligned
        logic [`RV_XLEN-1:0]   wdata;
        logic [`RV_XLEN/8-1:0] wstrb;  // Nonzero means store
    } dataReqT;

    // Retirement record
    typedef struct packed {
        logic                valid;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] data;
        logic [`RV_XLEN-1:0] pc;
    } commitT;

endpackage

// ==== rvCore.f ====
+incdir+hdl
hdl/rvPkg.sv
hdl/muxKeyWithDefault.sv
hdl/controller.sv
hdl/immGen.sv
hdl/alu.sv
hdl/regFile.sv
hdl/lsuAlign.sv
hdl/rvCore.sv
tests/rvCore_props.sv
tests/rvCore_tb.sv

// ==== tests/rvCore_props.sv ====
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module rvCoreProps
    import rvPkg::*;
(
    input logic                clk,
    input logic                arstN,
    input logic [`RV_XLEN-1:0] pc,
    input dataReqT             dataReq,
    input commitT              commit
);

    // No store may leave the core during reset
    apNoStoreInReset: assert property (@(posedge clk) !arstN |-> dataReq.wstrb == '0)
        else $error("Store strobe active while in reset");

    apPcAligned: assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
        else $error("PC is not word aligned");

    // Stores never retire a register write
    apStoreNoCommit: assert property (@(posedge clk) disable iff (!arstN)
        !(commit.valid && dataReq.wstrb != '0))
        else $error("Register commit and store in the same cycle");

    apNoX0Commit: assert property (@(posedge clk) disable iff (!arstN)
        commit.valid |-> commit.rd != '0)
        else $error("Commit reported for x0");

endmodule

// ==== tests/rvCore_tb.sv ====
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module rvCore_tb
    import rvPkg::*;
();

    localparam int RegAw = $clog2(`RV_NREGS);

    // RV32I major opcodes
    localparam logic [6:0] isaLoad   = 7'b0000011;
    localparam logic [6:0] isaStore  = 7'b0100011;
    localparam logic [6:0] isaImm    = 7'b0010011;
    localparam logic [6:0] isaReg    = 7'b0110011;
    localparam logic [6:0] isaLui    = 7'b0110111;
    localparam logic [6:0] isaAuipc  = 7'b0010111;
    localparam logic [6:0] isaJalr   = 7'b1100111;

    // One table row per instruction
    typedef struct {
        string       name;
        logic [31:0] word;
        logic        valid;   // Expected commit.valid
        logic [4:0]  rd;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] wdata;
        logic [31:0] addr;    // Word address of a store
        logic [31:0] nextPc;
    } vecT;

    logic        clk;
    logic        arstN;
    logic [31:0] pc;
    logic [31:0] instr;
    dataReqT     dataReq;
    logic [31:0] rdata;
    commitT      commit;

    logic [31:0] memSeed;     // Random base of the memory fill
    logic [31:0] bpc;         // PC tracked while building the table
    logic [31:0] expPc;
    bit          tableReady;
    int          errors;
    int          checks;
    vecT         vecs[$];

    rvCore DUT (
        .clk(clk), .arstN(arstN), .pc(pc), .instr(instr),
        .dataReq(dataReq), .rdata(rdata), .commit(commit)
    );

    bind rvCore rvCoreProps props (
        .clk(clk), .arstN(arstN), .pc(pc), .dataReq(dataReq), .commit(commit)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    // Data memory fill that depends on every address bit
    function automatic logic [31:0] fillWord(logic [31:0] seed, logic [31:0] addr);
        return seed ^ (addr * 32'h9E37_79B1);
    endfunction

    assign rdata = fillWord(memSeed, dataReq.addr);  // Asynchronous read

    // Load lane selection and extension
    function automatic logic [31:0] laneExt(logic [31:0] word, logic [1:0] off,
                                            bit half, bit sgn);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[off*8 +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        if (half)
            return sgn ? {{16{h[15]}}, h} : {16'h0, h};
        return sgn ? {{24{b[7]}}, b} : {24'h0, b};
    endfunction

    // Instruction encoders
    function automatic logic [31:0] iWord(logic [6:0] op, logic [RegAw-1:0] rd,
                                          logic [2:0] f3, logic [RegAw-1:0] rs1,
                                          logic [31:0] imm);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] rWord(logic [6:0] f7, logic [RegAw-1:0] rs2,
                                          logic [RegAw-1:0] rs1, logic [2:0] f3,
                                          logic [RegAw-1:0] rd);
        return {f7, rs2, rs1, f3, rd, isaReg};
    endfunction

    function automatic logic [31:0] sWord(logic [2:0] f3, logic [RegAw-1:0] rs1,
                                          logic [RegAw-1:0] rs2, logic [31:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], isaStore};
    endfunction

    function automatic logic [31:0] bWord(logic [2:0] f3, logic [RegAw-1:0] rs1,
                                          logic [RegAw-1:0] rs2, logic [31:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] uWord(logic [6:0] op, logic [RegAw-1:0] rd,
                                          logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jWord(logic [RegAw-1:0] rd, logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic pushVec(string name, logic [31:0] word, logic valid, logic [4:0] rd,
                           logic [31:0] data, logic [3:0] strb, logic [31:0] wdata,
                           logic [31:0] addr, logic [31:0] nextPc);
        vecT v;
        v = '{name, word, valid, rd, data, strb, wdata, addr, nextPc};
        vecs.push_back(v);
        bpc = nextPc;
    endtask

    task automatic wrVec(string name, logic [31:0] word, logic [4:0] rd, logic [31:0] data);
        pushVec(name, word, 1'b1, rd, data, 4'b0000, 32'h0, 32'h0, bpc + 4);
    endtask

    task automatic stVec(string name, logic [31:0] word, logic [3:0] strb,
                         logic [31:0] wdata, logic [31:0] addr);
        pushVec(name, word, 1'b0, 5'd0, 32'h0, strb, wdata, addr, bpc + 4);
    endtask

    task automatic brVec(string name, logic [31:0] word, bit taken, int off);
        pushVec(name, word, 1'b0, 5'd0, 32'h0, 4'b0000, 32'h0, 32'h0,
                taken ? bpc + off : bpc + 4);
    endtask

    task automatic buildTable();
        logic [31:0] base;
        base = 32'h0001_0000;  // x20 after lui
        // ALU ops with x1 = 0x80000000, x2 = -5 and x3 = 7
        wrVec("lui x1", uWord(isaLui, 1, 20'h80000), 1, 32'h8000_0000);
        wrVec("addi x2", iWord(isaImm, 2, 3'b000, 0, -5), 2, 32'hFFFF_FFFB);
        wrVec("addi x3", iWord(isaImm, 3, 3'b000, 0, 7), 3, 32'h7);
        wrVec("slti", iWord(isaImm, 4, 3'b010, 2, 0), 4, 32'h1);
        wrVec("sltiu", iWord(isaImm, 5, 3'b011, 3, -1), 5, 32'h1);
        wrVec("xori", iWord(isaImm, 6, 3'b100, 3, 32'h0F0), 6, 32'hF7);
        wrVec("ori", iWord(isaImm, 7, 3'b110, 3, 32'h100), 7, 32'h107);
        wrVec("andi", iWord(isaImm, 8, 3'b111, 2, 32'h0FF), 8, 32'hFB);
        wrVec("add", rWord(7'h00, 3, 2, 3'b000, 9), 9, 32'h2);
        wrVec("sub", rWord(7'h20, 2, 3, 3'b000, 10), 10, 32'hC);
        wrVec("sll", rWord(7'h00, 3, 3, 3'b001, 11), 11, 32'h380);
        wrVec("slt", rWord(7'h00, 3, 2, 3'b010, 12), 12, 32'h1);
        wrVec("sltu", rWord(7'h00, 3, 2, 3'b011, 13), 13, 32'h0);
        wrVec("xor", rWord(7'h00, 3, 2, 3'b100, 14), 14, 32'hFFFF_FFFC);
        wrVec("srl", rWord(7'h00, 3, 1, 3'b101, 15), 15, 32'h0100_0000);
        wrVec("sra", rWord(7'h20, 3, 1, 3'b101, 16), 16, 32'hFF00_0000);
        wrVec("or", rWord(7'h00, 3, 2, 3'b110, 17), 17, 32'hFFFF_FFFF);
        wrVec("and", rWord(7'h00, 3, 2, 3'b111, 18), 18, 32'h3);
        pushVec("addi x0", iWord(isaImm, 0, 3'b000, 3, 5), 1'b0, 5'd0, 32'h0,
                4'b0000, 32'h0, 32'h0, bpc + 4);  // Dropped write
        wrVec("add x19 x0", rWord(7'h00, 3, 0, 3'b000, 19), 19, 32'h7);
        // Loads from the fill pattern
        wrVec("lui x20", uWord(isaLui, 20, 20'h00010), 20, base);
        wrVec("lw", iWord(isaLoad, 21, 3'b010, 20, 4), 21, fillWord(memSeed, base + 4));
        for (int k = 0; k < 4; k++) begin
            wrVec($sformatf("lb +%0d", k), iWord(isaLoad, 22, 3'b000, 20, k), 22,
                  laneExt(fillWord(memSeed, base), k, 1'b0, 1'b1));
            wrVec($sformatf("lbu +%0d", k), iWord(isaLoad, 23, 3'b100, 20, k), 23,
                  laneExt(fillWord(memSeed, base), k, 1'b0, 1'b0));
        end
        for (int k = 0; k < 4; k += 2) begin
            wrVec($sformatf("lh +%0d", k), iWord(isaLoad, 24, 3'b001, 20, 16 + k), 24,
                  laneExt(fillWord(memSeed, base + 16), k, 1'b1, 1'b1));
            wrVec($sformatf("lhu +%0d", k), iWord(isaLoad, 25, 3'b101, 20, 16 + k), 25,
                  laneExt(fillWord(memSeed, base + 16), k, 1'b1, 1'b0));
        end
        // Stores replicate data across lanes
        stVec("sb +1", sWord(3'b000, 20, 2, 1), 4'b0010, 32'hFBFB_FBFB, base);
        stVec("sb +3", sWord(3'b000, 20, 3, 3), 4'b1000, 32'h0707_0707, base);
        stVec("sh +2", sWord(3'b001, 20, 14, 2), 4'b1100, 32'hFFFC_FFFC, base);
        stVec("sh +0", sWord(3'b001, 20, 7, 0), 4'b0011, 32'h0107_0107, base);
        stVec("sw", sWord(3'b010, 20, 7, 8), 4'b1111, 32'h0000_0107, base + 8);
        // Branches use negative x2 for the signed cases
        brVec("beq taken", bWord(3'b000, 3, 19, 8), 1'b1, 8);
        brVec("beq not", bWord(3'b000, 3, 2, 8), 1'b0, 8);
        brVec("bne taken", bWord(3'b001, 3, 2, 8), 1'b1, 8);
        brVec("bne not", bWord(3'b001, 3, 19, 8), 1'b0, 8);
        brVec("blt taken", bWord(3'b100, 2, 3, 8), 1'b1, 8);
        brVec("blt not", bWord(3'b100, 3, 2, 8), 1'b0, 8);
        brVec("bge taken", bWord(3'b101, 3, 2, 8), 1'b1, 8);
        brVec("bge not", bWord(3'b101, 2, 3, 8), 1'b0, 8);
        brVec("bltu taken", bWord(3'b110, 3, 2, -12), 1'b1, -12);  // Backward
        brVec("bltu not", bWord(3'b110, 2, 3, 8), 1'b0, 8);
        brVec("bgeu taken", bWord(3'b111, 2, 3, 16), 1'b1, 16);
        brVec("bgeu not", bWord(3'b111, 3, 2, 16), 1'b0, 16);
        // Jumps and auipc
        pushVec("jal", jWord(26, 16), 1'b1, 26, bpc + 4, 4'b0000, 32'h0, 32'h0, bpc + 16);
        pushVec("jalr", iWord(isaJalr, 27, 3'b000, 7, 32'hFA), 1'b1, 27, bpc + 4,
                4'b0000, 32'h0, 32'h0, 32'h0000_0200);  // 0x201 with bit 0 cleared
        wrVec("auipc", uWord(isaAuipc, 28, 20'h00001), 28, bpc + 32'h1000);
        pushVec("unknown", 32'hFFFF_FFFF, 1'b0, 5'd0, 32'h0, 4'b0000, 32'h0, 32'h0,
                bpc + 4);
    endtask

    task automatic checkVal(string name, string field, logic [31:0] exp, logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", name, field, exp, got);
        end
    endtask

    initial begin
        void'($urandom(32'h4481));
        memSeed = $urandom();
        arstN = 1'b1;
        instr = iWord(isaImm, 1, 3'b000, 0, 1);  // Would retire if not held in reset
        errors = 0;
        checks = 0;
        bpc = `RV_RESET_PC;
        expPc = `RV_RESET_PC;
        buildTable();
        tableReady = 1'b1;
        #1;
        arstN = 1'b0;  // Reset edge after time zero
        for (int n = 0; n < 8; n++) begin
            @(negedge clk);
            checkVal("reset", "pc", `RV_RESET_PC, pc);
            checkVal("reset", "commit.valid", 32'h0, 32'(commit.valid));
            checkVal("reset", "wstrb", 32'h0, 32'(dataReq.wstrb));
            // Second half of reset holds a store
            if (n == 3) begin
                @(posedge clk);
                #1;
                instr = sWord(3'b010, 0, 0, 0);
            end
        end
        foreach (vecs[i]) begin
            @(posedge clk);
            #1;
            arstN = 1'b1;
            instr = vecs[i].word;
            @(negedge clk);  // Outputs settled by mid cycle
            checkVal(vecs[i].name, "pc", expPc, pc);
            checkVal(vecs[i].name, "commit.pc", expPc, commit.pc);
            checkVal(vecs[i].name, "commit.valid", 32'(vecs[i].valid), 32'(commit.valid));
            if (vecs[i].valid) begin
                checkVal(vecs[i].name, "commit.rd", 32'(vecs[i].rd), 32'(commit.rd));
                checkVal(vecs[i].name, "commit.data", vecs[i].data, commit.data);
            end
            checkVal(vecs[i].name, "wstrb", 32'(vecs[i].strb), 32'(dataReq.wstrb));
            if (vecs[i].strb != 4'b0000) begin
                checkVal(vecs[i].name, "wdata", vecs[i].wdata, dataReq.wdata);
                checkVal(vecs[i].name, "addr", vecs[i].addr, dataReq.addr);
            end
            expPc = vecs[i].nextPc;
        end
        // Target of the last instruction
        @(posedge clk);
        #1;
        instr = iWord(isaImm, 0, 3'b000, 0, 0);
        @(negedge clk);
        checkVal("final", "pc", expPc, pc);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Run limit from table length
    initial begin
        wait (tableReady);
        #((vecs.size() + 20) * 10);
        $display("Watchdog expired, run did not finish in %0d cycles", vecs.size() + 20);
        $display("TESTS FAILED");
        $finish;
    end

endmodule
